// File: common/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define XLEN      32
`define NUM_REGS  32
`define REG_AW    5
`define RESET_PC  32'h0000_0000

// primary opcodes.
`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f
`define OP_LB      6'h20
`define OP_LW      6'h23
`define OP_LBU     6'h24
`define OP_SB      6'h28
`define OP_SW      6'h2b

// function codes under OP_SPECIAL.
`define FN_SLL     6'h00
`define FN_SRL     6'h02
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_SLT     6'h2a
`define FN_SLTU    6'h2b

`endif

// File: common/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [4:0]         shamt;
        logic [5:0]         funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [15:0]        imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } j_fmt_t;

    // one instruction word seen through the three MIPS formats.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB
    } mem_op_e;

    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        instr_t           instr;
    } if_id_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   rs_val;
        logic [`XLEN-1:0]   rt_val;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] dest;
        logic [`XLEN-1:0]   imm;
        logic [4:0]         shamt;
        alu_op_e            alu_op;
        logic               use_imm;
        mem_op_e            mem_op;
        logic               reg_write;
        logic               is_beq;
        logic               is_bne;
        logic               is_jump;
        logic [`XLEN-1:0]   jump_target;
    } id_ex_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   alu_result;
        logic [`XLEN-1:0]   store_data;
        logic [`REG_AW-1:0] dest;
        mem_op_e            mem_op;
        logic               reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   result;
        logic [`REG_AW-1:0] dest;
        logic               reg_write;
    } mem_wb_t;

endpackage

// File: decode/decode_stage.sv
`include "mips_defs.svh"

module decode_stage import mips_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    bubble,
    input  logic    squash,
    input  if_id_t  if_id,
    input  mem_wb_t mem_wb,
    output id_ex_t  id_ex
);

    logic [5:0]       op;
    logic             sign_ext;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] rs_val;
    logic [`XLEN-1:0] rt_val;
    id_ex_t           d;

    assign op       = if_id.instr.r_fmt.op;
    assign sign_ext = !(op inside {`OP_ANDI, `OP_ORI, `OP_XORI});
    assign pc_plus4 = if_id.pc + 32'd4;

    register_file u_regs (
        .clk     (clk),
        .rd_a    (if_id.instr.r_fmt.rs),
        .rd_b    (if_id.instr.r_fmt.rt),
        .wr_idx  (mem_wb.dest),
        .wr_en   (mem_wb.valid && mem_wb.reg_write),
        .wr_data (mem_wb.result),
        .a_val   (rs_val),
        .b_val   (rt_val)
    );

    always_comb begin
        d.valid       = 1'b1;
        d.pc          = if_id.pc;
        d.rs_val      = rs_val;
        d.rt_val      = rt_val;
        d.rs          = if_id.instr.r_fmt.rs;
        d.rt          = if_id.instr.r_fmt.rt;
        d.dest        = if_id.instr.i_fmt.rt;
        d.shamt       = if_id.instr.r_fmt.shamt;
        d.alu_op      = ALU_ADD;
        d.use_imm     = 1'b1;
        d.mem_op      = MEM_NONE;
        d.reg_write   = 1'b1;
        d.is_beq      = 1'b0;
        d.is_bne      = 1'b0;
        d.is_jump     = 1'b0;
        d.jump_target = {pc_plus4[31:28], if_id.instr.j_fmt.target, 2'b00};
        d.imm = sign_ext ? {{16{if_id.instr.i_fmt.imm[15]}}, if_id.instr.i_fmt.imm}
                         : {16'h0000, if_id.instr.i_fmt.imm};
        case (op)
            `OP_SPECIAL: begin
                d.dest    = if_id.instr.r_fmt.rd;
                d.use_imm = 1'b0;
                case (if_id.instr.r_fmt.funct)
                    `FN_ADDU: d.alu_op = ALU_ADD;
                    `FN_SUBU: d.alu_op = ALU_SUB;
                    `FN_AND:  d.alu_op = ALU_AND;
                    `FN_OR:   d.alu_op = ALU_OR;
                    `FN_XOR:  d.alu_op = ALU_XOR;
                    `FN_SLT:  d.alu_op = ALU_SLT;
                    `FN_SLTU: d.alu_op = ALU_SLTU;
                    `FN_SLL:  d.alu_op = ALU_SLL;
                    `FN_SRL:  d.alu_op = ALU_SRL;
                    default:  d.reg_write = 1'b0;
                endcase
            end
            `OP_ADDIU: d.alu_op = ALU_ADD;
            `OP_SLTI:  d.alu_op = ALU_SLT;
            `OP_ANDI:  d.alu_op = ALU_AND;
            `OP_ORI:   d.alu_op = ALU_OR;
            `OP_XORI:  d.alu_op = ALU_XOR;
            `OP_LUI:   d.alu_op = ALU_LUI;
            `OP_LW:    d.mem_op = MEM_LW;
            `OP_LB:    d.mem_op = MEM_LB;
            `OP_LBU:   d.mem_op = MEM_LBU;
            `OP_SW: begin
                d.mem_op    = MEM_SW;
                d.reg_write = 1'b0;
            end
            `OP_SB: begin
                d.mem_op    = MEM_SB;
                d.reg_write = 1'b0;
            end
            `OP_BEQ: begin
                d.is_beq    = 1'b1;
                d.reg_write = 1'b0;
            end
            `OP_BNE: begin
                d.is_bne    = 1'b1;
                d.reg_write = 1'b0;
            end
            `OP_J: begin
                d.is_jump   = 1'b1;
                d.reg_write = 1'b0;
            end
            // anything else passes through as a no-op.
            default: d.reg_write = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || squash || bubble) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            id_ex <= d;
        end
    end

endmodule

// File: decode/register_file.sv
`include "mips_defs.svh"

module register_file (
    input  logic               clk,
    input  logic [`REG_AW-1:0] rd_a,
    input  logic [`REG_AW-1:0] rd_b,
    input  logic [`REG_AW-1:0] wr_idx,
    input  logic               wr_en,
    input  logic [`XLEN-1:0]   wr_data,
    output logic [`XLEN-1:0]   a_val,
    output logic [`XLEN-1:0]   b_val
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // a write in the same cycle is passed straight to the reader.
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (wr_en && wr_idx == idx) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    always_comb begin
        a_val = read_port(rd_a);
        b_val = read_port(rd_b);
    end

endmodule

// File: design/cpu.sv
`include "mips_defs.svh"

module cpu import mips_pkg::*; (
    input  logic             clk,
    input  logic             rst,

    input  instr_t           im_out,
    output logic [`XLEN-1:0] im_addr,
    output logic             im_en,

    input  logic [`XLEN-1:0] dm_out,
    output logic [`XLEN-1:0] dm_addr,
    output logic [`XLEN-1:0] dm_in,
    output logic             dm_en,
    output logic [3:0]       dm_byte
);

    if_id_t           if_id;
    id_ex_t           id_ex;
    ex_mem_t          ex_mem;
    mem_wb_t          mem_wb;
    logic             stall;
    logic             bubble;
    logic             squash;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;
    logic [`XLEN-1:0] mem_result;
    fwd_sel_e         fwd_a;
    fwd_sel_e         fwd_b;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .squash      (squash),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .im_out      (im_out),
        .im_addr     (im_addr),
        .im_en       (im_en),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .bubble (bubble),
        .squash (squash),
        .if_id  (if_id),
        .mem_wb (mem_wb),
        .id_ex  (id_ex)
    );

    hazard_unit u_hazard (
        .if_id    (if_id),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .redirect (redirect),
        .stall    (stall),
        .bubble   (bubble),
        .squash   (squash),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst         (rst),
        .id_ex       (id_ex),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .mem_result  (mem_result),
        .wb_result   (mem_wb.result),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    memory_stage u_memory (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem),
        .dm_out     (dm_out),
        .dm_addr    (dm_addr),
        .dm_in      (dm_in),
        .dm_en      (dm_en),
        .dm_byte    (dm_byte),
        .mem_result (mem_result),
        .mem_wb     (mem_wb)
    );

endmodule

// File: design/hazard_unit.sv
`include "mips_defs.svh"

module hazard_unit import mips_pkg::*; (
    input  if_id_t   if_id,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    input  logic     redirect,
    output logic     stall,
    output logic     bubble,
    output logic     squash,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b
);

    logic load_ex;
    logic load_use;

    // the younger producer in memory takes priority over writeback.
    function automatic fwd_sel_e fwd_for(input logic [`REG_AW-1:0] idx);
        if (idx != '0 && ex_mem.valid && ex_mem.reg_write && ex_mem.dest == idx) begin
            return FWD_MEM;
        end else if (idx != '0 && mem_wb.valid && mem_wb.reg_write && mem_wb.dest == idx) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a = fwd_for(id_ex.rs);
        fwd_b = fwd_for(id_ex.rt);
    end

    assign load_ex  = id_ex.valid && id_ex.dest != '0
                      && id_ex.mem_op inside {MEM_LW, MEM_LB, MEM_LBU};
    assign load_use = load_ex && (id_ex.dest == if_id.instr.r_fmt.rs
                                  || id_ex.dest == if_id.instr.r_fmt.rt);

    // the dependent instruction is squashed anyway when execute redirects.
    assign stall  = load_use && !redirect;
    assign bubble = load_use;
    assign squash = redirect;

endmodule

// File: execute/execute_stage.sv
`include "mips_defs.svh"

module execute_stage import mips_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  id_ex_t           id_ex,
    input  fwd_sel_e         fwd_a,
    input  fwd_sel_e         fwd_b,
    input  logic [`XLEN-1:0] mem_result,
    input  logic [`XLEN-1:0] wb_result,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_pc,
    output ex_mem_t          ex_mem
);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] rt_fwd;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] alu_y;
    logic [`XLEN-1:0] br_target;
    logic             taken;

    function automatic logic [`XLEN-1:0] pick(input fwd_sel_e         sel,
                                              input logic [`XLEN-1:0] reg_val);
        case (sel)
            FWD_MEM: return mem_result;
            FWD_WB:  return wb_result;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        a      = pick(fwd_a, id_ex.rs_val);
        rt_fwd = pick(fwd_b, id_ex.rt_val);
    end

    assign b = id_ex.use_imm ? id_ex.imm : rt_fwd;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  alu_y = a + b;
            ALU_SUB:  alu_y = a - b;
            ALU_AND:  alu_y = a & b;
            ALU_OR:   alu_y = a | b;
            ALU_XOR:  alu_y = a ^ b;
            ALU_SLT:  alu_y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: alu_y = {{(`XLEN-1){1'b0}}, a < b};
            ALU_SLL:  alu_y = b << id_ex.shamt;
            ALU_SRL:  alu_y = b >> id_ex.shamt;
            ALU_LUI:  alu_y = {b[15:0], 16'h0000};
            default:  alu_y = a + b;
        endcase
    end

    // branch offsets count from the next instruction since there is no delay slot.
    assign br_target = id_ex.pc + 32'd4 + {id_ex.imm[`XLEN-3:0], 2'b00};

    assign taken = id_ex.is_jump
                   || (id_ex.is_beq && a == rt_fwd)
                   || (id_ex.is_bne && a != rt_fwd);

    assign redirect    = id_ex.valid && taken;
    assign redirect_pc = id_ex.is_jump ? id_ex.jump_target : br_target;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.alu_result <= alu_y;
            ex_mem.store_data <= rt_fwd;
            ex_mem.dest       <= id_ex.dest;
            ex_mem.mem_op     <= id_ex.mem_op;
            ex_mem.reg_write  <= id_ex.reg_write;
        end
    end

endmodule

// File: fetch/fetch_unit.sv
`include "mips_defs.svh"

module fetch_unit import mips_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             squash,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    input  instr_t           im_out,
    output logic [`XLEN-1:0] im_addr,
    output logic             im_en,
    output if_id_t           if_id
);

    logic [`XLEN-1:0] pc;

    assign im_addr = pc;
    assign im_en   = !stall;

    // a redirect from execute wins over a load-use stall.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // an all-zero word is sll $0 by zero and does nothing.
    always_ff @(posedge clk) begin
        if (rst || squash) begin
            if_id.instr <= '0;
        end else if (!stall) begin
            if_id.pc    <= pc;
            if_id.instr <= im_out;
        end
    end

endmodule

// File: flist.f
+incdir+common
+incdir+tests
common/mips_pkg.sv
fetch/fetch_unit.sv
decode/register_file.sv
decode/decode_stage.sv
design/hazard_unit.sv
execute/execute_stage.sv
memory/memory_stage.sv
design/cpu.sv
tests/tb_cpu.sv

// File: memory/memory_stage.sv
`include "mips_defs.svh"

module memory_stage import mips_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  ex_mem_t          ex_mem,
    input  logic [`XLEN-1:0] dm_out,
    output logic [`XLEN-1:0] dm_addr,
    output logic [`XLEN-1:0] dm_in,
    output logic             dm_en,
    output logic [3:0]       dm_byte,
    output logic [`XLEN-1:0] mem_result,
    output mem_wb_t          mem_wb
);

    logic [1:0]       lane;
    logic [7:0]       ld_byte;
    logic [`XLEN-1:0] ld_data;
    logic             is_load;

    assign lane    = ex_mem.alu_result[1:0];
    assign is_load = ex_mem.mem_op inside {MEM_LW, MEM_LB, MEM_LBU};

    assign dm_en   = ex_mem.valid && ex_mem.mem_op != MEM_NONE;
    assign dm_addr = {ex_mem.alu_result[`XLEN-1:2], 2'b00};

    // a byte store puts its data on every lane and the mask picks one.
    assign dm_in = (ex_mem.mem_op == MEM_SB) ? {4{ex_mem.store_data[7:0]}}
                                             : ex_mem.store_data;

    assign dm_byte = !ex_mem.valid              ? 4'b0000 :
                     ex_mem.mem_op == MEM_SW    ? 4'b1111 :
                     ex_mem.mem_op == MEM_SB    ? 4'b0001 << lane :
                                                  4'b0000;

    assign ld_byte = dm_out[8*lane +: 8];

    always_comb begin
        case (ex_mem.mem_op)
            MEM_LB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            MEM_LBU: ld_data = {24'h000000, ld_byte};
            default: ld_data = dm_out;
        endcase
    end

    assign mem_result = is_load ? ld_data : ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.result    <= mem_result;
            mem_wb.dest      <= ex_mem.dest;
            mem_wb.reg_write <= ex_mem.reg_write;
        end
    end

endmodule

// File: tests/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_TESTS  = 5;
localparam int PROG_WORDS = 16;
localparam int MAX_STORES = 8;

typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
} store_t;

instr_t prog      [NUM_TESTS][PROG_WORDS];
int     prog_len  [NUM_TESTS];
store_t exp_st    [NUM_TESTS][MAX_STORES];
int     n_stores  [NUM_TESTS];
int     n_loads   [NUM_TESTS];
int     n_stalls  [NUM_TESTS];
int     budget    [NUM_TESTS];
string  test_name [NUM_TESTS];

function automatic instr_t r_type(input logic [5:0] funct, input logic [4:0] rd,
                                  input logic [4:0] rs, input logic [4:0] rt,
                                  input logic [4:0] shamt);
    instr_t w;
    w.r_fmt.op    = `OP_SPECIAL;
    w.r_fmt.rs    = rs;
    w.r_fmt.rt    = rt;
    w.r_fmt.rd    = rd;
    w.r_fmt.shamt = shamt;
    w.r_fmt.funct = funct;
    return w;
endfunction

function automatic instr_t i_type(input logic [5:0] op, input logic [4:0] rt,
                                  input logic [4:0] rs, input logic [15:0] imm);
    instr_t w;
    w.i_fmt.op  = op;
    w.i_fmt.rs  = rs;
    w.i_fmt.rt  = rt;
    w.i_fmt.imm = imm;
    return w;
endfunction

// targets are word indices, since every program starts at address zero.
function automatic instr_t jump_to(input logic [25:0] target);
    instr_t w;
    w.j_fmt.op     = `OP_J;
    w.j_fmt.target = target;
    return w;
endfunction

task automatic emit(input int t, input instr_t w);
    prog[t][prog_len[t]] = w;
    prog_len[t]++;
endtask

task automatic expect_store(input int t, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] mask);
    exp_st[t][n_stores[t]] = '{addr: addr, data: data, mask: mask};
    n_stores[t]++;
endtask

task automatic build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
        prog_len[t] = 0;
        n_stores[t] = 0;
        n_loads[t]  = 0;
        n_stalls[t] = 0;
        budget[t]   = 30;
        for (int a = 0; a < PROG_WORDS; a++) begin
            prog[t][a] = '0;
        end
    end

    // dependent ALU chain, forwarded from both memory and writeback.
    test_name[0] = "alu chain";
    emit(0, i_type(`OP_LUI, 1, 0, 16'h1234));
    emit(0, i_type(`OP_ORI, 1, 1, 16'h5678));
    emit(0, i_type(`OP_ADDIU, 2, 0, 16'hffff));
    emit(0, r_type(`FN_ADDU, 3, 1, 2, 0));
    emit(0, i_type(`OP_SW, 3, 0, 16'h0000));
    emit(0, r_type(`FN_SUBU, 4, 0, 1, 0));
    emit(0, r_type(`FN_SLL, 5, 0, 4, 4));
    emit(0, r_type(`FN_SRL, 6, 0, 5, 8));
    emit(0, i_type(`OP_SW, 6, 0, 16'h0004));
    emit(0, r_type(`FN_SLT, 7, 4, 1, 0));
    emit(0, r_type(`FN_SLTU, 8, 4, 1, 0));
    emit(0, r_type(`FN_SLL, 7, 0, 7, 4));
    emit(0, r_type(`FN_OR, 9, 7, 8, 0));
    emit(0, i_type(`OP_SW, 9, 0, 16'h0008));
    emit(0, jump_to(14));
    expect_store(0, 32'h00, 32'h1234_5677, 4'b1111);
    expect_store(0, 32'h04, 32'h00dc_ba98, 4'b1111);
    expect_store(0, 32'h08, 32'h0000_0010, 4'b1111);

    test_name[1] = "load use";
    emit(1, i_type(`OP_LUI, 1, 0, 16'hcafe));
    emit(1, i_type(`OP_ORI, 1, 1, 16'h1234));
    emit(1, i_type(`OP_SW, 1, 0, 16'h0010));
    emit(1, i_type(`OP_LW, 2, 0, 16'h0010));
    emit(1, i_type(`OP_ADDIU, 3, 2, 16'h0011));
    emit(1, i_type(`OP_SW, 3, 0, 16'h0014));
    emit(1, i_type(`OP_LW, 4, 0, 16'h0014));
    emit(1, i_type(`OP_SW, 4, 0, 16'h0018));
    emit(1, i_type(`OP_ADDIU, 5, 4, 16'hffbb));
    emit(1, i_type(`OP_SW, 5, 0, 16'h001c));
    emit(1, jump_to(10));
    expect_store(1, 32'h10, 32'hcafe_1234, 4'b1111);
    expect_store(1, 32'h14, 32'hcafe_1245, 4'b1111);
    expect_store(1, 32'h18, 32'hcafe_1245, 4'b1111);
    expect_store(1, 32'h1c, 32'hcafe_1200, 4'b1111);
    // both loads feed the very next instruction, so each costs one stall.
    n_loads[1]  = 2;
    n_stalls[1] = 2;

    // one byte per lane, then read back signed and unsigned.
    test_name[2] = "byte lanes";
    emit(2, i_type(`OP_ADDIU, 1, 0, 16'h0081));
    emit(2, i_type(`OP_SB, 1, 0, 16'h0020));
    emit(2, i_type(`OP_ADDIU, 2, 0, 16'h007f));
    emit(2, i_type(`OP_SB, 2, 0, 16'h0021));
    emit(2, i_type(`OP_ADDIU, 3, 0, 16'h00c3));
    emit(2, i_type(`OP_SB, 3, 0, 16'h0022));
    emit(2, i_type(`OP_ADDIU, 4, 0, 16'h0025));
    emit(2, i_type(`OP_SB, 4, 0, 16'h0023));
    emit(2, i_type(`OP_LB, 5, 0, 16'h0020));
    emit(2, i_type(`OP_LBU, 6, 0, 16'h0022));
    emit(2, i_type(`OP_LB, 7, 0, 16'h0021));
    emit(2, i_type(`OP_SW, 5, 0, 16'h0024));
    emit(2, i_type(`OP_SW, 6, 0, 16'h0028));
    emit(2, i_type(`OP_SW, 7, 0, 16'h002c));
    emit(2, jump_to(14));
    expect_store(2, 32'h20, 32'h8181_8181, 4'b0001);
    expect_store(2, 32'h20, 32'h7f7f_7f7f, 4'b0010);
    expect_store(2, 32'h20, 32'hc3c3_c3c3, 4'b0100);
    expect_store(2, 32'h20, 32'h2525_2525, 4'b1000);
    expect_store(2, 32'h24, 32'hffff_ff81, 4'b1111);
    expect_store(2, 32'h28, 32'h0000_00c3, 4'b1111);
    expect_store(2, 32'h2c, 32'h0000_007f, 4'b1111);
    n_loads[2] = 3;

    // stores at words 3, 4 and 10 sit in the shadow of taken branches.
    test_name[3] = "branches";
    emit(3, i_type(`OP_ADDIU, 1, 0, 16'd5));
    emit(3, i_type(`OP_ADDIU, 2, 0, 16'd5));
    emit(3, i_type(`OP_BEQ, 2, 1, 16'd2));
    emit(3, i_type(`OP_SW, 1, 0, 16'h0030));
    emit(3, i_type(`OP_SW, 2, 0, 16'h0034));
    emit(3, i_type(`OP_ADDIU, 3, 0, 16'd7));
    emit(3, i_type(`OP_BNE, 2, 1, 16'd2));
    emit(3, i_type(`OP_SW, 3, 0, 16'h0038));
    emit(3, i_type(`OP_SW, 1, 0, 16'h003c));
    emit(3, i_type(`OP_BNE, 1, 3, 16'd1));
    emit(3, i_type(`OP_SW, 0, 0, 16'h0040));
    emit(3, i_type(`OP_BEQ, 1, 3, 16'd1));
    emit(3, i_type(`OP_SW, 3, 0, 16'h0044));
    emit(3, jump_to(13));
    expect_store(3, 32'h38, 32'h0000_0007, 4'b1111);
    expect_store(3, 32'h3c, 32'h0000_0005, 4'b1111);
    expect_store(3, 32'h44, 32'h0000_0007, 4'b1111);

    // words 4 and 5 are undefined encodings that would overwrite $1 and $2.
    test_name[4] = "jump and unknown opcodes";
    emit(4, i_type(`OP_ADDIU, 1, 0, 16'h1111));
    emit(4, jump_to(3));
    emit(4, i_type(`OP_SW, 1, 0, 16'h0048));
    emit(4, i_type(`OP_ADDIU, 2, 0, 16'h2222));
    emit(4, i_type(6'h3f, 1, 0, 16'h7777));
    emit(4, r_type(6'h3f, 2, 1, 1, 0));
    emit(4, i_type(`OP_ANDI, 3, 2, 16'h0f0f));
    emit(4, i_type(`OP_XORI, 3, 3, 16'hffff));
    emit(4, i_type(`OP_SLTI, 4, 2, 16'h2223));
    emit(4, r_type(`FN_XOR, 5, 3, 4, 0));
    emit(4, i_type(`OP_SW, 1, 0, 16'h004c));
    emit(4, i_type(`OP_SW, 2, 0, 16'h0050));
    emit(4, i_type(`OP_SW, 5, 0, 16'h0054));
    emit(4, jump_to(13));
    expect_store(4, 32'h4c, 32'h0000_1111, 4'b1111);
    expect_store(4, 32'h50, 32'h0000_2222, 4'b1111);
    expect_store(4, 32'h54, 32'h0000_fdfc, 4'b1111);
endtask

`endif

// File: tests/tb_cpu.sv
`include "mips_defs.svh"

module tb_cpu import mips_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int MARGIN_CYCLES = 50;
    localparam int DMEM_WORDS    = 64;

    `include "tb_programs.svh"

    logic             clk;
    logic             rst;
    instr_t           im_out;
    logic [`XLEN-1:0] im_addr;
    logic             im_en;
    logic [`XLEN-1:0] dm_out;
    logic [`XLEN-1:0] dm_addr;
    logic [`XLEN-1:0] dm_in;
    logic             dm_en;
    logic [3:0]       dm_byte;

    instr_t           imem [PROG_WORDS];
    logic [`XLEN-1:0] dmem [DMEM_WORDS];

    int   error_count;
    int   test_errors;
    int   pass_count;
    int   fail_count;
    int   watchdog_ns;
    logic table_ready;

    cpu dut (
        .clk     (clk),
        .rst     (rst),
        .im_out  (im_out),
        .im_addr (im_addr),
        .im_en   (im_en),
        .dm_out  (dm_out),
        .dm_addr (dm_addr),
        .dm_in   (dm_in),
        .dm_en   (dm_en),
        .dm_byte (dm_byte)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // both memories answer in the same cycle; the program wraps every 16 words.
    assign im_out = imem[im_addr[5:2]];
    assign dm_out = dmem[dm_addr[7:2]];

    always @(posedge clk) begin
        if (dm_en) begin
            for (int i = 0; i < 4; i++) begin
                if (dm_byte[i]) begin
                    dmem[dm_addr[7:2]][8*i +: 8] <= dm_in[8*i +: 8];
                end
            end
        end
    end

    task automatic load_program(input int t);
        for (int a = 0; a < PROG_WORDS; a++) begin
            imem[a] = prog[t][a];
        end
        for (int a = 0; a < DMEM_WORDS; a++) begin
            dmem[a] = '0;
        end
    endtask

    // the program is swapped in after the first reset edge, while the pipeline is empty.
    task automatic apply_reset(input int t);
        @(posedge clk);
        rst <= 1'b1;
        for (int c = 1; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            @(negedge clk);
            if (c == 1) begin
                load_program(t);
            end
            if (dm_byte !== 4'b0000) begin
                $display("mismatch at %0d ns: dm_byte expected 0000 got %b", $time, dm_byte);
                test_errors++;
            end
        end
        @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int seen;
        int stalls;
        int accesses;
        store_t e;
        seen = 0;
        stalls = 0;
        accesses = 0;
        test_errors = 0;
        apply_reset(t);
        for (int c = 0; c < budget[t]; c++) begin
            @(negedge clk);
            if (im_en !== 1'b1) begin
                stalls++;
            end
            if (dm_en === 1'b1) begin
                accesses++;
            end
            if (dm_byte !== 4'b0000) begin
                if (seen >= n_stores[t]) begin
                    $display("unexpected store at %0d ns to address %h with data %h, lanes %b",
                             $time, dm_addr, dm_in, dm_byte);
                    test_errors++;
                end else begin
                    e = exp_st[t][seen];
                    if (dm_en !== 1'b1) begin
                        $display("mismatch at %0d ns: dm_en expected 1 got %b", $time, dm_en);
                        test_errors++;
                    end
                    if (dm_addr !== e.addr) begin
                        $display("mismatch at %0d ns: dm_addr expected %h got %h",
                                 $time, e.addr, dm_addr);
                        test_errors++;
                    end
                    if (dm_in !== e.data) begin
                        $display("mismatch at %0d ns: dm_in expected %h got %h",
                                 $time, e.data, dm_in);
                        test_errors++;
                    end
                    if (dm_byte !== e.mask) begin
                        $display("mismatch at %0d ns: dm_byte expected %b got %b",
                                 $time, e.mask, dm_byte);
                        test_errors++;
                    end
                end
                seen++;
            end
        end
        if (seen < n_stores[t]) begin
            $display("stores missing in %s: expected %0d, saw only %0d",
                     test_name[t], n_stores[t], seen);
            test_errors++;
        end
        if (stalls != n_stalls[t]) begin
            $display("mismatch at %0d ns: im_en low cycles expected %0d got %0d",
                     $time, n_stalls[t], stalls);
            test_errors++;
        end
        if (accesses != n_stores[t] + n_loads[t]) begin
            $display("mismatch at %0d ns: dm_en high cycles expected %0d got %0d",
                     $time, n_stores[t] + n_loads[t], accesses);
            test_errors++;
        end
        error_count += test_errors;
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d (%s): pass", t, test_name[t]);
        end else begin
            fail_count++;
            $display("test %0d (%s): fail with %0d errors", t, test_name[t], test_errors);
        end
    endtask

    initial begin
        int total_cycles;
        rst         = 1'b1;
        table_ready = 1'b0;
        error_count = 0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        for (int a = 0; a < PROG_WORDS; a++) begin
            imem[a] = '0;
        end
        for (int a = 0; a < DMEM_WORDS; a++) begin
            dmem[a] = '0;
        end
        build_table();
        total_cycles = MARGIN_CYCLES;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_cycles += budget[t] + RESET_CYCLES + 1;
        end
        watchdog_ns = total_cycles * CLK_PERIOD;
        table_ready = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("%0d of %0d tests passed, %0d failed, %0d errors in total",
                 pass_count, NUM_TESTS, fail_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (table_ready === 1'b1);
        #(watchdog_ns);
        $display("timeout: the tests did not complete within %0d ns", watchdog_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule
